/* rtl/gat_defines.svh */
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// layer size.
`define GAT_NUM_ELEMS 12

// datapath widths.
`define GAT_FEAT_W  8
`define GAT_WGT_W   8
`define GAT_PROD_W  16
`define GAT_ACC_W   32
`define GAT_IDX_W   4
`define GAT_ADDR_W  8

// element indices whose products the monitor keeps.
`define GAT_DBG_CAP_A 2
`define GAT_DBG_CAP_B 9

`endif

/* rtl/gat_pkg.sv */
`default_nettype none

`include "gat_defines.svh"

package gat_pkg;

  // sequencer state, doubles as the datapath opcode.
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    SPMM = 3'd1,
    DMVM = 3'd2,
    AGGR = 3'd3,
    DONE = 3'd4
  } stage_e;

  typedef struct packed {
    logic                   ena;
    logic [`GAT_ADDR_W-1:0] addr;
    logic [`GAT_FEAT_W-1:0] din;
  } feat_wr_t;

  typedef struct packed {
    stage_e                op;
    logic                  elem_vld;
    logic [`GAT_IDX_W-1:0] idx;
  } stage_ctrl_t;

  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_evt_t;

  typedef struct packed {
    logic                   vld;
    logic [`GAT_IDX_W-1:0]  idx;
    logic [`GAT_PROD_W-1:0] data;
  } prod_wr_t;

  typedef struct packed {
    logic [5:0]  stage_seen;    // same order as stage_evt_t.
    logic        feat_ena_seen;
    logic        addr_err;
    logic [15:0] elem_count;
    logic [15:0] cap_a;
    logic [15:0] cap_b;
  } dbg_status_t;

endpackage

`default_nettype wire

/* rtl/stage_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module stage_sequencer import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  logic        last_i,
  output stage_ctrl_t ctrl_o,
  output stage_evt_t  evt_o,
  output logic        cnt_clr_o,
  output logic        cnt_en_o,
  output logic        busy_o,
  output logic        done_o
);

  stage_e state_q, state_d;
  logic   entry_q, entry_d;  // first cycle of a stage.
  logic   done_q;
  logic   running;
  logic   elem_cyc;

  assign running  = (state_q == SPMM) || (state_q == DMVM) || (state_q == AGGR);
  assign elem_cyc = running && !entry_q;

  //////////////////////////////////////////////////////////////////////
  // state walk
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    entry_d = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = SPMM;
          entry_d = 1'b1;
        end
      end
      SPMM, DMVM, AGGR: begin
        if (elem_cyc && last_i) begin
          state_d = (state_q == SPMM) ? DMVM :
                    (state_q == DMVM) ? AGGR : DONE;
          entry_d = (state_q != AGGR);
        end
      end
      DONE:    state_d = IDLE;  // single cycle.
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      entry_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      entry_q <= entry_d;
      done_q  <= (state_q == DONE);  // lines up with the result load.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // strobes
  //////////////////////////////////////////////////////////////////////

  assign cnt_clr_o = running && entry_q;
  assign cnt_en_o  = elem_cyc;

  assign ctrl_o.op       = state_q;
  assign ctrl_o.elem_vld = elem_cyc;
  assign ctrl_o.idx      = '0;  // top fills in the counter index.

  assign evt_o.spmm_vld = (state_q == SPMM) && entry_q;
  assign evt_o.spmm_rdy = (state_q == SPMM) && elem_cyc && last_i;
  assign evt_o.dmvm_vld = (state_q == DMVM) && entry_q;
  assign evt_o.dmvm_rdy = (state_q == DMVM) && elem_cyc && last_i;
  assign evt_o.aggr_vld = (state_q == AGGR) && entry_q;
  assign evt_o.aggr_rdy = (state_q == AGGR) && elem_cyc && last_i;

  assign busy_o = (state_q != IDLE);
  assign done_o = done_q;

endmodule

`default_nettype wire

/* rtl/elem_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module elem_counter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clr_i,
  input  logic                  en_i,
  output logic [`GAT_IDX_W-1:0] idx_o,
  output logic                  last_o
);

  localparam logic [`GAT_IDX_W-1:0] LAST_IDX = `GAT_IDX_W'(`GAT_NUM_ELEMS - 1);

  logic [`GAT_IDX_W-1:0] idx_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q <= '0;
    end else if (clr_i) begin
      idx_q <= '0;
    end else if (en_i) begin
      idx_q <= last_o ? '0 : idx_q + 1'b1;  // wrap after the final element.
    end
  end

  assign idx_o  = idx_q;
  assign last_o = (idx_q == LAST_IDX);

endmodule

`default_nettype wire

/* rtl/spmm_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module spmm_unit import gat_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  feat_wr_t               feat_wr_i,
  input  logic [`GAT_WGT_W-1:0]  weight_i,
  input  stage_ctrl_t            ctrl_i,
  input  logic [`GAT_IDX_W-1:0]  rd_idx_i,
  output logic [`GAT_PROD_W-1:0] rd_data_o,
  output prod_wr_t               prod_wr_o,
  output logic                   wr_err_o
);

  localparam int PW = `GAT_PROD_W;

  logic [`GAT_FEAT_W-1:0] feat_mem [`GAT_NUM_ELEMS];
  logic [`GAT_PROD_W-1:0] prod_mem [`GAT_NUM_ELEMS];

  logic                   addr_ok;
  logic                   prod_we;
  logic [`GAT_PROD_W-1:0] prod_calc;
  logic                   prod_vld_q;
  logic                   wr_err_q;
  logic [`GAT_IDX_W-1:0]  prod_idx_q;
  logic [`GAT_PROD_W-1:0] prod_data_q;

  assign addr_ok   = (feat_wr_i.addr < `GAT_NUM_ELEMS);
  assign prod_we   = ctrl_i.elem_vld && (ctrl_i.op == SPMM);
  assign prod_calc = PW'(feat_mem[ctrl_i.idx]) * PW'(weight_i);

  // host side feature file, kept across runs.
  always_ff @(posedge clk) begin
    if (feat_wr_i.ena && addr_ok) begin
      feat_mem[feat_wr_i.addr[`GAT_IDX_W-1:0]] <= feat_wr_i.din;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_we) begin
      prod_mem[ctrl_i.idx] <= prod_calc;
      prod_idx_q           <= ctrl_i.idx;
      prod_data_q          <= prod_calc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_vld_q <= 1'b0;
      wr_err_q   <= 1'b0;
    end else begin
      prod_vld_q <= prod_we;
      wr_err_q   <= feat_wr_i.ena && !addr_ok;  // out of range write.
    end
  end

  assign rd_data_o      = prod_mem[rd_idx_i];
  assign prod_wr_o.vld  = prod_vld_q;
  assign prod_wr_o.idx  = prod_idx_q;
  assign prod_wr_o.data = prod_data_q;
  assign wr_err_o       = wr_err_q;

endmodule

`default_nettype wire

/* rtl/accum_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module accum_unit import gat_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  stage_ctrl_t            ctrl_i,
  input  logic [`GAT_WGT_W-1:0]  att_i,
  input  logic [`GAT_PROD_W-1:0] prod_i,
  output logic [`GAT_ACC_W-1:0]  score_o,
  output logic [`GAT_ACC_W-1:0]  agg_o
);

  localparam int AW = `GAT_ACC_W;

  logic [`GAT_ACC_W-1:0] score_acc;
  logic [`GAT_ACC_W-1:0] agg_acc;
  logic [`GAT_ACC_W-1:0] score_q;
  logic [`GAT_ACC_W-1:0] agg_q;
  logic [`GAT_ACC_W-1:0] att_term;

  assign att_term = AW'(prod_i) * AW'(att_i);

  //////////////////////////////////////////////////////////////////////
  // running sums
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_acc <= '0;
      agg_acc   <= '0;
    end else begin
      unique case (ctrl_i.op)
        SPMM: begin  // fresh run.
          score_acc <= '0;
          agg_acc   <= '0;
        end
        DMVM:    if (ctrl_i.elem_vld) score_acc <= score_acc + att_term;
        AGGR:    if (ctrl_i.elem_vld) agg_acc <= agg_acc + AW'(prod_i);
        default: ;
      endcase
    end
  end

  // published results, held until the next run finishes.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_q <= '0;
      agg_q   <= '0;
    end else if (ctrl_i.op == DONE) begin
      score_q <= score_acc;
      agg_q   <= agg_acc;
    end
  end

  assign score_o = score_q;
  assign agg_o   = agg_q;

endmodule

`default_nettype wire

/* rtl/debug_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module debug_monitor import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clr_i,
  input  stage_evt_t  evt_i,
  input  feat_wr_t    feat_wr_i,
  input  logic        wr_err_i,
  input  prod_wr_t    prod_wr_i,
  input  stage_ctrl_t ctrl_i,
  output dbg_status_t dbg_o
);

  logic [5:0]  stage_seen_q;
  logic        ena_seen_q;
  logic        addr_err_q;
  logic [15:0] elem_count_q;
  logic [15:0] cap_a_q;
  logic [15:0] cap_b_q;

  logic        count_hit;
  logic        cap_a_hit;
  logic        cap_b_hit;

  assign count_hit = ctrl_i.elem_vld && ((ctrl_i.op == DMVM) || (ctrl_i.op == AGGR));
  assign cap_a_hit = prod_wr_i.vld && (prod_wr_i.idx == `GAT_IDX_W'(`GAT_DBG_CAP_A));
  assign cap_b_hit = prod_wr_i.vld && (prod_wr_i.idx == `GAT_IDX_W'(`GAT_DBG_CAP_B));

  //////////////////////////////////////////////////////////////////////
  // sticky flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_seen_q <= '0;
      ena_seen_q   <= 1'b0;
      addr_err_q   <= 1'b0;
    end else if (clr_i) begin
      stage_seen_q <= '0;
      ena_seen_q   <= 1'b0;
      addr_err_q   <= 1'b0;
    end else begin
      stage_seen_q <= stage_seen_q | evt_i;
      ena_seen_q   <= ena_seen_q | feat_wr_i.ena;
      addr_err_q   <= addr_err_q | wr_err_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // element count and product captures
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      elem_count_q <= '0;
      cap_a_q      <= '0;
      cap_b_q      <= '0;
    end else if (clr_i) begin
      elem_count_q <= '0;
      cap_a_q      <= '0;
      cap_b_q      <= '0;
    end else begin
      if (count_hit) elem_count_q <= elem_count_q + 16'd1;
      if (cap_a_hit) cap_a_q <= prod_wr_i.data;
      if (cap_b_hit) cap_b_q <= prod_wr_i.data;
    end
  end

  assign dbg_o.stage_seen    = stage_seen_q;
  assign dbg_o.feat_ena_seen = ena_seen_q;
  assign dbg_o.addr_err      = addr_err_q;
  assign dbg_o.elem_count    = elem_count_q;
  assign dbg_o.cap_a         = cap_a_q;
  assign dbg_o.cap_b         = cap_b_q;

endmodule

`default_nettype wire

/* rtl/gat_layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module gat_layer_top import gat_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  feat_wr_t              feat_wr_i,
  input  logic [`GAT_WGT_W-1:0] weight_i,
  input  logic [`GAT_WGT_W-1:0] att_i,
  input  logic                  dbg_clr_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic [`GAT_ACC_W-1:0] score_o,
  output logic [`GAT_ACC_W-1:0] agg_o,
  output dbg_status_t           dbg_o
);

  stage_ctrl_t            seq_ctrl;
  stage_ctrl_t            ctrl;
  stage_evt_t             evt;
  prod_wr_t               prod_wr;
  logic                   cnt_clr;
  logic                   cnt_en;
  logic                   cnt_last;
  logic                   wr_err;
  logic [`GAT_IDX_W-1:0]  cnt_idx;
  logic [`GAT_PROD_W-1:0] rd_data;

  // element index rides with the sequencer opcode.
  assign ctrl = '{op: seq_ctrl.op, elem_vld: seq_ctrl.elem_vld, idx: cnt_idx};

  stage_sequencer u_seq (
    .clk, .rst_n, .start_i, .last_i(cnt_last), .ctrl_o(seq_ctrl), .evt_o(evt),
    .cnt_clr_o(cnt_clr), .cnt_en_o(cnt_en), .busy_o, .done_o
  );

  elem_counter u_cnt (
    .clk, .rst_n, .clr_i(cnt_clr), .en_i(cnt_en), .idx_o(cnt_idx), .last_o(cnt_last)
  );

  spmm_unit u_spmm (
    .clk, .rst_n, .feat_wr_i, .weight_i, .ctrl_i(ctrl), .rd_idx_i(cnt_idx),
    .rd_data_o(rd_data), .prod_wr_o(prod_wr), .wr_err_o(wr_err)
  );

  accum_unit u_acc (
    .clk, .rst_n, .ctrl_i(ctrl), .att_i, .prod_i(rd_data), .score_o, .agg_o
  );

  debug_monitor u_dbg (
    .clk, .rst_n, .clr_i(dbg_clr_i), .evt_i(evt), .feat_wr_i, .wr_err_i(wr_err),
    .prod_wr_i(prod_wr), .ctrl_i(ctrl), .dbg_o
  );

endmodule

`default_nettype wire

/* testbench/gat_layer_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module gat_layer_properties import gat_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  busy_o,
  input logic                  done_o,
  input logic [`GAT_IDX_W-1:0] cnt_idx,
  input stage_evt_t            evt
);

  localparam int N = `GAT_NUM_ELEMS;

  done_single: assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o)
    else $error("done_o longer than one cycle");

  busy_drop: assert property (@(posedge clk) disable iff (!rst_n) $fell(busy_o) |-> done_o)
    else $error("busy_o fell without done_o");

  done_idle: assert property (@(posedge clk) disable iff (!rst_n) done_o |-> !busy_o)
    else $error("busy_o high during done_o");

  idx_range: assert property (@(posedge clk) disable iff (!rst_n) cnt_idx < N)
    else $error("element index out of range");

  // each stage ends exactly one element sweep after it starts.
  spmm_seq: assert property (@(posedge clk) disable iff (!rst_n)
    evt.spmm_vld |-> ##N evt.spmm_rdy) else $error("spmm rdy missing");
  dmvm_seq: assert property (@(posedge clk) disable iff (!rst_n)
    evt.dmvm_vld |-> ##N evt.dmvm_rdy) else $error("dmvm rdy missing");
  aggr_seq: assert property (@(posedge clk) disable iff (!rst_n)
    evt.aggr_vld |-> ##N evt.aggr_rdy) else $error("aggr rdy missing");

endmodule

bind gat_layer_top gat_layer_properties props_i (
  .clk, .rst_n, .busy_o, .done_o, .cnt_idx, .evt
);

`default_nettype wire

/* testbench/tb_gat_layer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module tb_gat_layer import gat_pkg::*; ();

  localparam int N_ELEMS    = `GAT_NUM_ELEMS;
  localparam int N_RUNS     = 4;
  localparam int MAX_CYCLES = N_RUNS * (3 * N_ELEMS + 20) + 4 * N_ELEMS + 100;

  typedef struct packed {
    logic [`GAT_ACC_W-1:0]  score;
    logic [`GAT_ACC_W-1:0]  agg;
    logic [`GAT_PROD_W-1:0] cap_a;
    logic [`GAT_PROD_W-1:0] cap_b;
  } layer_res_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   start_i;
  feat_wr_t               feat_wr_i;
  logic [`GAT_WGT_W-1:0]  weight_i;
  logic [`GAT_WGT_W-1:0]  att_i;
  logic                   dbg_clr_i;
  logic                   busy_o;
  logic                   done_o;
  logic [`GAT_ACC_W-1:0]  score_o;
  logic [`GAT_ACC_W-1:0]  agg_o;
  dbg_status_t            dbg_o;

  logic [`GAT_FEAT_W-1:0] model_feat [N_ELEMS];  // host view of the buffer.
  layer_res_t             exp_res;
  logic [`GAT_ACC_W-1:0]  prev_score;
  integer                 seed = 32'h77bb;
  int                     done_cnt = 0;
  int                     runs = 0;
  int                     cycle_cnt = 0;
  int                     elem_base = 0;

  always #5 clk = ~clk;

  gat_layer_top dut_i (
    .clk, .rst_n, .start_i, .feat_wr_i, .weight_i, .att_i, .dbg_clr_i,
    .busy_o, .done_o, .score_o, .agg_o, .dbg_o
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      fail_now($sformatf("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                         $time, name, got, exp));
    end
  endtask

  // score, aggregate and captures straight from the layer equations.
  function automatic layer_res_t layer_model(input logic [`GAT_WGT_W-1:0] w,
                                             input logic [`GAT_WGT_W-1:0] a);
    layer_res_t             r;
    logic [`GAT_PROD_W-1:0] p;
    r = '0;
    for (int i = 0; i < N_ELEMS; i++) begin
      p       = 16'(model_feat[i]) * 16'(w);
      r.score = r.score + 32'(p) * 32'(a);
      r.agg   = r.agg + 32'(p);
      if (i == `GAT_DBG_CAP_A) r.cap_a = p;
      if (i == `GAT_DBG_CAP_B) r.cap_b = p;
    end
    return r;
  endfunction

  task automatic load_features();
    logic [`GAT_FEAT_W-1:0] din;
    for (int i = 0; i < N_ELEMS; i++) begin
      din           = 8'($random(seed));
      model_feat[i] = din;
      feat_wr_i     = '{ena: 1'b1, addr: 8'(i), din: din};
      @(negedge clk);
    end
    feat_wr_i = '0;
  endtask

  task automatic run_layer(input logic poke_busy);
    exp_res = layer_model(weight_i, att_i);
    runs++;
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    check_equal("busy_o", 64'(busy_o), 64'd1);
    if (poke_busy) begin
      repeat (N_ELEMS + N_ELEMS / 2) @(negedge clk);
      start_i = 1'b1;  // lands mid dmvm.
      @(negedge clk);
      start_i = 1'b0;
    end
    while (done_cnt != runs) @(negedge clk);
    repeat (4) @(negedge clk);
    assert (!busy_o && done_cnt == runs) else begin
      fail_now("a start pulse during a run was accepted");
    end
    elem_base += 2 * N_ELEMS;
  endtask

  task automatic verify_debug(input logic ena_exp);
    check_equal("dbg_o.stage_seen", 64'(dbg_o.stage_seen), 64'h3f);
    check_equal("dbg_o.feat_ena_seen", 64'(dbg_o.feat_ena_seen), 64'(ena_exp));
    check_equal("dbg_o.elem_count", 64'(dbg_o.elem_count), 64'(elem_base));
    check_equal("dbg_o.cap_a", 64'(dbg_o.cap_a), 64'(exp_res.cap_a));
    check_equal("dbg_o.cap_b", 64'(dbg_o.cap_b), 64'(exp_res.cap_b));
  endtask

  //////////////////////////////////////////////////////////////////////
  // result compare and run limit
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n && done_o) begin
      done_cnt++;
      assert (done_cnt <= runs) else begin
        fail_now("done_o pulsed without an accepted start");
      end
      check_equal("score_o", 64'(score_o), 64'(exp_res.score));
      check_equal("agg_o", 64'(agg_o), 64'(exp_res.agg));
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a run never finished", cycle_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n     = 1'b0;
    start_i   = 1'b0;
    feat_wr_i = '0;
    weight_i  = '0;
    att_i     = '0;
    dbg_clr_i = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_equal("done_o", 64'(done_o), 64'd0);
    check_equal("busy_o", 64'(busy_o), 64'd0);
    check_equal("score_o", 64'(score_o), 64'd0);
    check_equal("agg_o", 64'(agg_o), 64'd0);
    check_equal("dbg_o", 64'(dbg_o), 64'd0);

    load_features();
    weight_i = 8'($random(seed));
    att_i    = 8'($random(seed));
    run_layer(1'b0);
    verify_debug(1'b1);

    weight_i = 8'($random(seed));  // new weight, start poked while busy.
    run_layer(1'b1);
    verify_debug(1'b1);
    prev_score = exp_res.score;

    // writes past the buffer end.
    feat_wr_i = '{ena: 1'b1, addr: 8'(N_ELEMS), din: 8'($random(seed))};
    @(negedge clk);
    feat_wr_i = '{ena: 1'b1, addr: 8'(16 + 16 * ($random(seed) & 32'h7)),
                  din: ~model_feat[0]};  // low bits alias element 0.
    @(negedge clk);
    feat_wr_i = '0;
    repeat (2) @(negedge clk);
    check_equal("dbg_o.addr_err", 64'(dbg_o.addr_err), 64'd1);
    run_layer(1'b0);
    check_equal("score_o", 64'(score_o), 64'(prev_score));
    verify_debug(1'b1);

    load_features();
    dbg_clr_i = 1'b1;
    @(negedge clk);
    dbg_clr_i = 1'b0;
    @(negedge clk);
    check_equal("dbg_o", 64'(dbg_o), 64'd0);
    elem_base = 0;
    att_i     = 8'($random(seed));
    run_layer(1'b0);
    verify_debug(1'b0);  // no feature writes since the clear.

    if (done_cnt == N_RUNS) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "run count mismatch");
    end
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/gat_pkg.sv
rtl/stage_sequencer.sv
rtl/elem_counter.sv
rtl/spmm_unit.sv
rtl/accum_unit.sv
rtl/debug_monitor.sv
rtl/gat_layer_top.sv
testbench/gat_layer_properties.sv
testbench/tb_gat_layer.sv

/* Makefile */
TOP = tb_gat_layer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
